/* design/jtag_pkg.sv */
`default_nettype none

package jtag_pkg;

	localparam int IR_WIDTH      = 4;
	localparam int DATA_WIDTH    = 16;
	localparam int DOMAIN_WIDTH  = 3;
	localparam int REG_IDX_WIDTH = 4;
	localparam int CMD_WIDTH     = 24;

	localparam logic [IR_WIDTH-1:0] INSTR_IDCODE     = 4'h1;
	localparam logic [IR_WIDTH-1:0] INSTR_DBG_ACCESS = 4'h8;
	localparam logic [IR_WIDTH-1:0] INSTR_BYPASS     = 4'hF;

	// Bit 0 must be set per IEEE 1149.1
	localparam logic [31:0] IDCODE_VALUE = 32'h4a7c_0e35;

	typedef enum logic [3:0] {
		TAP_RESET, TAP_IDLE,
		TAP_SEL_DR, TAP_CAP_DR, TAP_SHIFT_DR, TAP_EXIT1_DR, TAP_PAUSE_DR, TAP_EXIT2_DR, TAP_UPD_DR,
		TAP_SEL_IR, TAP_CAP_IR, TAP_SHIFT_IR, TAP_EXIT1_IR, TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPD_IR
	} tap_state_e;

	// Shifted in, decoded at Update-DR
	typedef struct packed {
		logic                     write;
		logic [DOMAIN_WIDTH-1:0]  domain;
		logic [REG_IDX_WIDTH-1:0] reg_idx;
		logic [DATA_WIDTH-1:0]    wdata;
	} debug_cmd_s;

	// Loaded at Capture-DR
	typedef struct packed {
		logic                             valid;
		logic                             err;
		logic [CMD_WIDTH-DATA_WIDTH-3:0]  zero;
		logic [DATA_WIDTH-1:0]            rdata;
	} debug_rsp_s;

	// LSB goes out first
	typedef union packed {
		debug_cmd_s cmd;
		debug_rsp_s rsp;
	} debug_word_u;

endpackage

`default_nettype wire

/* design/jtag_pin_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module jtag_pin_sync (
	input  wire logic clk_i,
	input  wire logic arst_n_i,
	input  wire logic tck_i,
	input  wire logic tms_i,
	input  wire logic tdi_i,
	input  wire logic trst_n_i,
	output logic      tck_rise_o,
	output logic      tck_fall_o,
	output logic      tms_o,
	output logic      tdi_o,
	output logic      trst_n_o
);
	logic [1:0] tck_sync;
	logic [1:0] tms_sync;
	logic [1:0] tdi_sync;
	logic [1:0] trst_sync;
	logic       tck_q;
	logic       trst_arst_n;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tck_sync   <= '0;
			tms_sync   <= '1;
			tdi_sync   <= '0;
			tck_q      <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
		end else begin
			tck_sync   <= {tck_sync[0], tck_i};
			tms_sync   <= {tms_sync[0], tms_i};
			tdi_sync   <= {tdi_sync[0], tdi_i};
			// Third flop for edge detect
			tck_q      <= tck_sync[1];
			tck_rise_o <= tck_sync[1] & ~tck_q;
			tck_fall_o <= ~tck_sync[1] & tck_q;
		end
	end

	// TRST asserts at once, releases through two flops
	assign trst_arst_n = arst_n_i & trst_n_i;

	always_ff @(posedge clk_i or negedge trst_arst_n) begin
		if (!trst_arst_n) begin
			trst_sync <= '0;
		end else begin
			trst_sync <= {trst_sync[0], 1'b1};
		end
	end

	assign tms_o    = tms_sync[1];
	assign tdi_o    = tdi_sync[1];
	assign trst_n_o = trst_sync[1];

endmodule

`default_nettype wire

/* design/jtag_tap.sv */
`timescale 1ns/1ns
`default_nettype none

module jtag_tap (
	input  wire logic                               clk_i,
	input  wire logic                               arst_n_i,
	input  wire logic                               tck_rise_i,
	input  wire logic                               tck_fall_i,
	input  wire logic                               tms_i,
	input  wire logic                               tdi_i,
	input  wire logic                               trst_n_i,
	input  wire logic                               rsp_valid_i,
	input  wire logic                               rsp_err_i,
	input  wire logic [jtag_pkg::DATA_WIDTH-1:0]    rsp_rdata_i,
	output logic                                    tdo_o,
	output logic                                    cmd_stb_o,
	output logic                                    cmd_write_o,
	output logic [jtag_pkg::DOMAIN_WIDTH-1:0]       cmd_domain_o,
	output logic [jtag_pkg::REG_IDX_WIDTH-1:0]      cmd_reg_idx_o,
	output logic [jtag_pkg::DATA_WIDTH-1:0]         cmd_wdata_o
);
	jtag_pkg::tap_state_e          state;
	jtag_pkg::tap_state_e          next_state;
	logic [jtag_pkg::IR_WIDTH-1:0] ir;
	logic [jtag_pkg::IR_WIDTH-1:0] ir_sr;
	logic [31:0]                   idcode_sr;
	logic                          bypass_sr;
	jtag_pkg::debug_word_u         dbg_sr;
	logic                          tck_rise_q;
	logic                          dr_tdo;

	always_comb begin
		next_state = state;
		case (state)
			jtag_pkg::TAP_RESET:    next_state = tms_i ? jtag_pkg::TAP_RESET    : jtag_pkg::TAP_IDLE;
			jtag_pkg::TAP_IDLE:     next_state = tms_i ? jtag_pkg::TAP_SEL_DR   : jtag_pkg::TAP_IDLE;
			jtag_pkg::TAP_SEL_DR:   next_state = tms_i ? jtag_pkg::TAP_SEL_IR   : jtag_pkg::TAP_CAP_DR;
			jtag_pkg::TAP_CAP_DR:   next_state = tms_i ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_SHIFT_DR: next_state = tms_i ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_EXIT1_DR: next_state = tms_i ? jtag_pkg::TAP_UPD_DR   : jtag_pkg::TAP_PAUSE_DR;
			jtag_pkg::TAP_PAUSE_DR: next_state = tms_i ? jtag_pkg::TAP_EXIT2_DR : jtag_pkg::TAP_PAUSE_DR;
			jtag_pkg::TAP_EXIT2_DR: next_state = tms_i ? jtag_pkg::TAP_UPD_DR   : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_UPD_DR:   next_state = tms_i ? jtag_pkg::TAP_SEL_DR   : jtag_pkg::TAP_IDLE;
			jtag_pkg::TAP_SEL_IR:   next_state = tms_i ? jtag_pkg::TAP_RESET    : jtag_pkg::TAP_CAP_IR;
			jtag_pkg::TAP_CAP_IR:   next_state = tms_i ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_SHIFT_IR: next_state = tms_i ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_EXIT1_IR: next_state = tms_i ? jtag_pkg::TAP_UPD_IR   : jtag_pkg::TAP_PAUSE_IR;
			jtag_pkg::TAP_PAUSE_IR: next_state = tms_i ? jtag_pkg::TAP_EXIT2_IR : jtag_pkg::TAP_PAUSE_IR;
			jtag_pkg::TAP_EXIT2_IR: next_state = tms_i ? jtag_pkg::TAP_UPD_IR   : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_UPD_IR:   next_state = tms_i ? jtag_pkg::TAP_SEL_DR   : jtag_pkg::TAP_IDLE;
			default:                next_state = jtag_pkg::TAP_RESET;
		endcase
	end

	// Unknown codes fall through to bypass
	always_comb begin
		case (ir)
			jtag_pkg::INSTR_IDCODE:     dr_tdo = idcode_sr[0];
			jtag_pkg::INSTR_DBG_ACCESS: dr_tdo = dbg_sr[0];
			default:                    dr_tdo = bypass_sr;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= jtag_pkg::TAP_RESET;
			ir         <= jtag_pkg::INSTR_IDCODE;
			tck_rise_q <= 1'b0;
			cmd_stb_o  <= 1'b0;
			tdo_o      <= 1'b0;
		end else begin
			tck_rise_q <= tck_rise_i;
			if (!trst_n_i) begin
				state <= jtag_pkg::TAP_RESET;
			end else if (tck_rise_i) begin
				state <= next_state;
			end
			if (state == jtag_pkg::TAP_RESET) begin
				ir <= jtag_pkg::INSTR_IDCODE;
			end else if (tck_rise_q && state == jtag_pkg::TAP_UPD_IR) begin
				ir <= ir_sr;
			end
			// One clock after the rise that entered Update-DR
			cmd_stb_o <= tck_rise_q && state == jtag_pkg::TAP_UPD_DR &&
				ir == jtag_pkg::INSTR_DBG_ACCESS;
			if (tck_fall_i) begin
				case (state)
					jtag_pkg::TAP_SHIFT_IR: tdo_o <= ir_sr[0];
					jtag_pkg::TAP_SHIFT_DR: tdo_o <= dr_tdo;
					default:                tdo_o <= 1'b0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (tck_rise_i) begin
			case (state)
				jtag_pkg::TAP_CAP_IR: ir_sr <= {{(jtag_pkg::IR_WIDTH-1){1'b0}}, 1'b1};
				jtag_pkg::TAP_SHIFT_IR: ir_sr <= {tdi_i, ir_sr[jtag_pkg::IR_WIDTH-1:1]};
				jtag_pkg::TAP_CAP_DR: begin
					idcode_sr        <= jtag_pkg::IDCODE_VALUE;
					bypass_sr        <= 1'b0;
					dbg_sr.rsp.valid <= rsp_valid_i;
					dbg_sr.rsp.err   <= rsp_err_i;
					dbg_sr.rsp.zero  <= '0;
					dbg_sr.rsp.rdata <= rsp_rdata_i;
				end
				jtag_pkg::TAP_SHIFT_DR: begin
					case (ir)
						jtag_pkg::INSTR_IDCODE: idcode_sr <= {tdi_i, idcode_sr[31:1]};
						jtag_pkg::INSTR_DBG_ACCESS:
							dbg_sr <= {tdi_i, dbg_sr[jtag_pkg::CMD_WIDTH-1:1]};
						default: bypass_sr <= tdi_i;
					endcase
				end
				default: ;
			endcase
		end
		if (tck_rise_q && state == jtag_pkg::TAP_UPD_DR) begin
			cmd_write_o   <= dbg_sr.cmd.write;
			cmd_domain_o  <= dbg_sr.cmd.domain;
			cmd_reg_idx_o <= dbg_sr.cmd.reg_idx;
			cmd_wdata_o   <= dbg_sr.cmd.wdata;
		end
	end

	// TCK edges from the pin sync are never back to back
	a_stb_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		cmd_stb_o |=> !cmd_stb_o);

endmodule

`default_nettype wire

/* design/debug_reg_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module debug_reg_bank #(
	parameter int DOMAIN_ID   = 0,
	parameter int CFG_REGS    = 4,
	parameter int STATUS_REGS = 2
) (
	input  wire logic                                       clk_i,
	input  wire logic                                       arst_n_i,
	input  wire logic                                       cmd_stb_i,
	input  wire logic                                       cmd_write_i,
	input  wire logic [jtag_pkg::DOMAIN_WIDTH-1:0]          cmd_domain_i,
	input  wire logic [jtag_pkg::REG_IDX_WIDTH-1:0]         cmd_reg_idx_i,
	input  wire logic [jtag_pkg::DATA_WIDTH-1:0]            cmd_wdata_i,
	input  wire logic [STATUS_REGS*jtag_pkg::DATA_WIDTH-1:0] status_i,
	output logic [CFG_REGS*jtag_pkg::DATA_WIDTH-1:0]        cfg_o,
	output logic                                            hit_o,
	output logic                                            err_o,
	output logic [jtag_pkg::DATA_WIDTH-1:0]                 rdata_o
);
	localparam int DW = jtag_pkg::DATA_WIDTH;

	logic          sel;
	logic          is_cfg;
	logic          is_status;
	logic          bad;
	logic [DW-1:0] rd_val;

	assign sel       = cmd_stb_i && int'(cmd_domain_i) == DOMAIN_ID;
	assign is_cfg    = int'(cmd_reg_idx_i) < CFG_REGS;
	assign is_status = !is_cfg && int'(cmd_reg_idx_i) < CFG_REGS + STATUS_REGS;
	// Status words are read only
	assign bad       = !(is_cfg || (is_status && !cmd_write_i));

	// A write echoes its data, errors return zero
	always_comb begin
		rd_val = '0;
		if (is_cfg) begin
			rd_val = cmd_write_i ? cmd_wdata_i : cfg_o[int'(cmd_reg_idx_i)*DW +: DW];
		end else if (is_status && !cmd_write_i) begin
			rd_val = status_i[(int'(cmd_reg_idx_i) - CFG_REGS)*DW +: DW];
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cfg_o <= '0;
			hit_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			hit_o <= sel;
			err_o <= sel && bad;
			if (sel && cmd_write_i && is_cfg) begin
				cfg_o[int'(cmd_reg_idx_i)*DW +: DW] <= cmd_wdata_i;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (sel) begin
			rdata_o <= rd_val;
		end
	end

	a_cfg_only_on_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!$stable(cfg_o) |-> hit_o && !err_o);

endmodule

`default_nettype wire

/* design/jtag_readback_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module jtag_readback_mux #(
	parameter int NUM_DOMAINS = 4
) (
	input  wire logic                                        clk_i,
	input  wire logic                                        arst_n_i,
	input  wire logic                                        cmd_stb_i,
	input  wire logic [NUM_DOMAINS-1:0]                      hit_i,
	input  wire logic [NUM_DOMAINS-1:0]                      err_i,
	input  wire logic [NUM_DOMAINS*jtag_pkg::DATA_WIDTH-1:0] rdata_i,
	output logic                                             rsp_valid_o,
	output logic                                             rsp_err_o,
	output logic [jtag_pkg::DATA_WIDTH-1:0]                  rsp_rdata_o
);
	localparam int DW = jtag_pkg::DATA_WIDTH;

	logic          stb_q;
	logic [DW-1:0] hit_rdata;

	always_comb begin
		hit_rdata = '0;
		for (int d = 0; d < NUM_DOMAINS; d++) begin
			if (hit_i[d]) begin
				hit_rdata = hit_rdata | rdata_i[d*DW +: DW];
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stb_q       <= 1'b0;
			rsp_valid_o <= 1'b0;
			rsp_err_o   <= 1'b0;
			rsp_rdata_o <= '0;
		end else begin
			stb_q <= cmd_stb_i;
			// Banks answer one clock after the strobe
			if (stb_q) begin
				rsp_valid_o <= 1'b1;
				if (|hit_i) begin
					rsp_err_o   <= |(hit_i & err_i);
					rsp_rdata_o <= hit_rdata;
				end else begin
					// Domain out of range
					rsp_err_o   <= 1'b1;
					rsp_rdata_o <= '0;
				end
			end
		end
	end

	a_hit_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0(hit_i));

endmodule

`default_nettype wire

/* design/jtag_top.sv */
`timescale 1ns/1ns
`default_nettype none

module jtag_top #(
	parameter int NUM_DOMAINS = 4,
	parameter int CFG_REGS    = 4,
	parameter int STATUS_REGS = 2
) (
	input  wire logic                                                    clk_i,
	input  wire logic                                                    arst_n_i,
	input  wire logic                                                    tck_i,
	input  wire logic                                                    tms_i,
	input  wire logic                                                    tdi_i,
	input  wire logic                                                    trst_n_i,
	input  wire logic [NUM_DOMAINS*STATUS_REGS*jtag_pkg::DATA_WIDTH-1:0] status_i,
	output logic                                                         tdo_o,
	output logic [NUM_DOMAINS*CFG_REGS*jtag_pkg::DATA_WIDTH-1:0]         cfg_o
);
	logic tck_rise, tck_fall, tms, tdi, trst_n;
	logic cmd_stb, cmd_write;
	logic [jtag_pkg::DOMAIN_WIDTH-1:0]  cmd_domain;
	logic [jtag_pkg::REG_IDX_WIDTH-1:0] cmd_reg_idx;
	logic [jtag_pkg::DATA_WIDTH-1:0]    cmd_wdata;
	logic [NUM_DOMAINS-1:0] bank_hit, bank_err;
	logic [NUM_DOMAINS*jtag_pkg::DATA_WIDTH-1:0] bank_rdata;
	logic rsp_valid, rsp_err;
	logic [jtag_pkg::DATA_WIDTH-1:0] rsp_rdata;

	jtag_pin_sync u_pin_sync (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i),
		.trst_n_i(trst_n_i), .tck_rise_o(tck_rise), .tck_fall_o(tck_fall), .tms_o(tms),
		.tdi_o(tdi), .trst_n_o(trst_n)
	);

	jtag_tap u_tap (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .tck_rise_i(tck_rise), .tck_fall_i(tck_fall),
		.tms_i(tms), .tdi_i(tdi), .trst_n_i(trst_n), .rsp_valid_i(rsp_valid),
		.rsp_err_i(rsp_err), .rsp_rdata_i(rsp_rdata), .tdo_o(tdo_o), .cmd_stb_o(cmd_stb),
		.cmd_write_o(cmd_write), .cmd_domain_o(cmd_domain), .cmd_reg_idx_o(cmd_reg_idx),
		.cmd_wdata_o(cmd_wdata)
	);

	for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_bank
		debug_reg_bank #(.DOMAIN_ID(d), .CFG_REGS(CFG_REGS), .STATUS_REGS(STATUS_REGS)) u_bank (
			.clk_i(clk_i), .arst_n_i(arst_n_i), .cmd_stb_i(cmd_stb), .cmd_write_i(cmd_write),
			.cmd_domain_i(cmd_domain), .cmd_reg_idx_i(cmd_reg_idx), .cmd_wdata_i(cmd_wdata),
			.status_i(status_i[d*STATUS_REGS*jtag_pkg::DATA_WIDTH +: STATUS_REGS*jtag_pkg::DATA_WIDTH]),
			.cfg_o(cfg_o[d*CFG_REGS*jtag_pkg::DATA_WIDTH +: CFG_REGS*jtag_pkg::DATA_WIDTH]),
			.hit_o(bank_hit[d]), .err_o(bank_err[d]),
			.rdata_o(bank_rdata[d*jtag_pkg::DATA_WIDTH +: jtag_pkg::DATA_WIDTH])
		);
	end

	jtag_readback_mux #(.NUM_DOMAINS(NUM_DOMAINS)) u_readback (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .cmd_stb_i(cmd_stb), .hit_i(bank_hit),
		.err_i(bank_err), .rdata_i(bank_rdata), .rsp_valid_o(rsp_valid), .rsp_err_o(rsp_err),
		.rsp_rdata_o(rsp_rdata)
	);

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic arst_n_o
);
	initial begin
		clk_o    = 1'b0;
		arst_n_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Release on a falling edge, away from the DUT's sampling edge
	initial begin
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end
endmodule

`default_nettype wire

/* tb/jtag_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module jtag_tb;
	localparam int ND          = 4;
	localparam int CFG         = 4;
	localparam int ST          = 2;
	localparam int DW          = jtag_pkg::DATA_WIDTH;
	localparam int HALF_TCK    = 8;
	localparam int NUM_ENTRIES = 17;
	// Reset, IDCODE, three IR scans and two bypass scans
	localparam int EXTRA_SCANS = 7;
	localparam int TIMEOUT_CYCLES = (NUM_ENTRIES * 2 + EXTRA_SCANS) * 40 * 2 * HALF_TCK + 500;

	typedef struct packed {
		logic          write;
		logic [2:0]    domain;
		logic [3:0]    reg_idx;
		logic [DW-1:0] wdata;
		logic          exp_valid;
		logic          exp_err;
		logic [DW-1:0] exp_rdata;
	} entry_t;

	logic                 clk;
	logic                 arst_n;
	logic                 tck;
	logic                 tms;
	logic                 tdi;
	logic                 trst_n;
	logic                 tdo;
	logic [ND*ST*DW-1:0]  status;
	logic [ND*CFG*DW-1:0] cfg;
	logic [ND*CFG*DW-1:0] exp_cfg;
	logic [DW-1:0]        shadow [ND][CFG];
	entry_t               stim_tbl [NUM_ENTRIES];
	int                   num_built;
	logic [31:0]          lfsr_state;
	int                   cycle_count;

	tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

	jtag_top #(.NUM_DOMAINS(ND), .CFG_REGS(CFG), .STATUS_REGS(ST)) dut (
		.clk_i(clk), .arst_n_i(arst_n), .tck_i(tck), .tms_i(tms), .tdi_i(tdi),
		.trst_n_i(trst_n), .status_i(status), .tdo_o(tdo), .cfg_o(cfg)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("Timeout after %0d clock cycles, the tests did not finish",
				cycle_count));
		end
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(negedge clk);
		tck = 1'b0;
		tms = tms_v;
		tdi = tdi_v;
		repeat (HALF_TCK) @(negedge clk);
		// TDO settled since the falling TCK
		tdo_v = tdo;
		tck = 1'b1;
		repeat (HALF_TCK - 1) @(negedge clk);
	endtask

	task automatic tap_reset();
		logic b;
		repeat (5) tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic scan_ir(input logic [3:0] code);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < jtag_pkg::IR_WIDTH; i++) begin
			tck_cycle(i == jtag_pkg::IR_WIDTH - 1, code[i], b);
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic scan_dr(input int len, input logic [31:0] din, output logic [31:0] dout);
		logic b;
		dout = '0;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		// Capture-DR to Shift-DR
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], b);
			dout[i] = b;
		end
		// Exit1-DR to Update-DR, then Idle
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic scan_word(input jtag_pkg::debug_word_u cmd,
			output jtag_pkg::debug_word_u rsp);
		logic [31:0] dout;
		scan_dr(jtag_pkg::CMD_WIDTH, {8'h00, cmd}, dout);
		rsp = dout[jtag_pkg::CMD_WIDTH-1:0];
	endtask

	task automatic check_rsp(input int idx, input jtag_pkg::debug_word_u got,
			input logic want_valid, input logic want_err, input logic [DW-1:0] want_rdata);
		if (got.rsp.valid !== want_valid || got.rsp.err !== want_err ||
				got.rsp.zero !== '0 || got.rsp.rdata !== want_rdata) begin
			fail_run($sformatf(
				"CHECK FAILED at %0t: entry %0d response v=%b e=%b z=%h d=%h, want v=%b e=%b d=%h",
				$time, idx, got.rsp.valid, got.rsp.err, got.rsp.zero, got.rsp.rdata,
				want_valid, want_err, want_rdata));
		end
	endtask

	task automatic check_scan32(input string what, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			fail_run($sformatf("CHECK FAILED at %0t: %s scan %h, expected %h",
				$time, what, got, want));
		end
	endtask

	task automatic check_cfg(input int idx, input logic [ND*CFG*DW-1:0] got,
			input logic [ND*CFG*DW-1:0] want);
		if (got !== want) begin
			fail_run($sformatf("CHECK FAILED at %0t: entry %0d cfg_o %h, expected %h",
				$time, idx, got, want));
		end
	endtask

	task automatic add_entry(input logic write, input int domain, input int reg_idx);
		entry_t      e;
		logic [31:0] r;
		e = '0;
		e.write     = write;
		e.domain    = domain[2:0];
		e.reg_idx   = reg_idx[3:0];
		e.exp_valid = 1'b1;
		if (write) begin
			take_bits(DW, r);
			e.wdata = r[DW-1:0];
		end
		if (domain >= ND) begin
			e.exp_err = 1'b1;
		end else if (reg_idx < CFG) begin
			// A write reads back its own data
			e.exp_rdata = write ? e.wdata : shadow[domain][reg_idx];
			if (write) begin
				shadow[domain][reg_idx] = e.wdata;
			end
		end else if (reg_idx < CFG + ST && !write) begin
			e.exp_rdata = status[(domain * ST + reg_idx - CFG) * DW +: DW];
		end else begin
			e.exp_err = 1'b1;
		end
		stim_tbl[num_built] = e;
		num_built++;
	endtask

	task automatic build_table();
		num_built = 0;
		for (int d = 0; d < ND; d++) begin
			for (int r = 0; r < CFG; r++) begin
				shadow[d][r] = '0;
			end
		end
		add_entry(1'b1, 0, 0);
		add_entry(1'b1, 1, 3);
		add_entry(1'b1, 3, 2);
		add_entry(1'b0, 0, 0);
		add_entry(1'b0, 1, 3);
		add_entry(1'b0, 3, 2);
		add_entry(1'b0, 2, 4);
		add_entry(1'b0, 3, 5);
		// Error cases
		add_entry(1'b1, 1, 4);
		add_entry(1'b0, 0, 6);
		add_entry(1'b1, 2, 9);
		add_entry(1'b0, 4, 0);
		add_entry(1'b1, 7, 1);
		add_entry(1'b1, 0, 0);
		add_entry(1'b0, 0, 0);
		add_entry(1'b0, 1, 1);
		add_entry(1'b0, 2, 15);
	endtask

	initial begin
		jtag_pkg::debug_word_u cmd;
		jtag_pkg::debug_word_u follow;
		jtag_pkg::debug_word_u rsp;
		logic [31:0]           din;
		logic [31:0]           dout;
		tck        = 1'b0;
		tms        = 1'b1;
		tdi        = 1'b0;
		trst_n     = 1'b0;
		lfsr_state = 32'h30f1bdd6;
		for (int w = 0; w < ND * ST; w++) begin
			take_bits(DW, din);
			status[w*DW +: DW] = din[DW-1:0];
		end
		exp_cfg = '0;
		build_table();
		wait (arst_n);
		@(negedge clk);
		trst_n = 1'b1;
		tap_reset();

		// IDCODE is selected out of reset
		scan_dr(32, 32'h0, dout);
		check_scan32("IDCODE", dout, jtag_pkg::IDCODE_VALUE);

		// Bypass and an unknown code, one TCK of delay
		for (int k = 0; k < 2; k++) begin
			scan_ir(k == 0 ? jtag_pkg::INSTR_BYPASS : 4'h5);
			take_bits(16, din);
			scan_dr(16, din, dout);
			check_scan32("BYPASS", dout, {16'h0, din[14:0], 1'b0});
		end

		scan_ir(jtag_pkg::INSTR_DBG_ACCESS);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			cmd = '0;
			cmd.cmd.write   = stim_tbl[i].write;
			cmd.cmd.domain  = stim_tbl[i].domain;
			cmd.cmd.reg_idx = stim_tbl[i].reg_idx;
			cmd.cmd.wdata   = stim_tbl[i].wdata;
			scan_word(cmd, rsp);
			if (stim_tbl[i].write && !stim_tbl[i].exp_err) begin
				exp_cfg[(int'(stim_tbl[i].domain) * CFG + int'(stim_tbl[i].reg_idx)) * DW +: DW] =
					stim_tbl[i].wdata;
			end
			check_cfg(i, cfg, exp_cfg);
			// Harmless re-read fetches the response
			follow = cmd;
			follow.cmd.write = 1'b0;
			scan_word(follow, rsp);
			check_rsp(i, rsp, stim_tbl[i].exp_valid, stim_tbl[i].exp_err,
				stim_tbl[i].exp_rdata);
		end

		$display("Test OK");
		$finish;
	end
endmodule

`default_nettype wire

/* sim.f */
design/jtag_pkg.sv
design/jtag_pin_sync.sv
design/jtag_tap.sv
design/debug_reg_bank.sv
design/jtag_readback_mux.sv
design/jtag_top.sv
tb/tb_clk_gen.sv
tb/jtag_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       := jtag_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK" || { echo "Simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
